// ==== verilog/cpu_ctrl_consts.svh ====
`ifndef CPU_CTRL_CONSTS_SVH
`define CPU_CTRL_CONSTS_SVH

// stack and port opcodes
`define OP_PUSH      5'b00111
`define OP_OUT       5'b00110
`define OP_IN        5'b01111
`define OP_POP       5'b10000
`define OP_LDM       5'b10001
`define OP_LOAD      5'b10010
`define OP_STORE     5'b10011

// all branches share the top three bits
`define OP_BRANCH_HI 3'b101

`define OP_CALL      5'b11000
`define OP_RET       5'b11001
`define OP_RTI       5'b11010

// alu ops taking the instruction immediate
`define OP_IMM_A     5'b01101
`define OP_IMM_B     5'b01110

// register-writing alu ops, plus every 01xxx opcode
`define OP_REG_A     5'b00011
`define OP_REG_B     5'b00100
`define OP_REG_C     5'b00101
`define OP_REG_D     5'b01000
`define OP_REG_HI    2'b01

// program counter source
`define PC_SEL_NEXT  2'b00
`define PC_SEL_RSVD  2'b01
`define PC_SEL_INT   2'b10
`define PC_SEL_JUMP  2'b11

// memory write data source
`define MEM_DATA_REG   2'b00
`define MEM_DATA_PC_LO 2'b01
`define MEM_DATA_PC_HI 2'b10
`define MEM_DATA_FLAGS 2'b11

`endif

// ==== verilog/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

  typedef logic [4:0] opcode_t;
  typedef logic [1:0] pc_sel_t;
  typedef logic [1:0] mem_data_sel_t;

  // bit 1 load-immediate operand, bit 0 instruction immediate
  typedef logic [1:0] alu_src_t;

  typedef enum logic [0:0] {LDM_IDLE, LDM_HOLD} ldm_state_e;

  typedef enum logic [0:0] {CALL_IDLE, CALL_PUSH_HI} call_state_e;

  typedef enum logic [1:0] {RET_IDLE, RET_WAIT, RET_POP_HI, RET_POP_LO} ret_state_e;

  typedef enum logic [3:0] {
    INT_IDLE,
    INT_ACK,
    INT_HAZARD_WAIT,
    INT_FREEZE_PC,
    INT_FREEZE_CU,
    INT_WAIT_3,
    INT_WAIT_4,
    INT_PUSH_LO,
    INT_PUSH_HI,
    INT_PUSH_FLAGS
  } int_state_e;

  typedef enum logic [1:0] {RTI_IDLE, RTI_POP_FLAGS, RTI_POP_HI, RTI_POP_LO} rti_state_e;

  typedef struct packed {
    opcode_t  alu_op;
    alu_src_t alu_src;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    logic     stack;
    logic     ldm;
    logic     branch;
    logic     port_read;
    logic     port_write;
    logic     call;
    logic     ret;
    logic     rti;
  } decode_ctrl_t;

  // request from one stack sequencer
  typedef struct packed {
    logic    mem_read;
    logic    mem_write;
    logic    stack;
    logic    pc_to_stack1;
    logic    pc_to_stack2;
    logic    ccr_to_stack;
    logic    pop_pc1;
    logic    pop_pc2;
    logic    pop_ccr;
    logic    freeze_pc;
    logic    freeze_cu;
    logic    flush;
    pc_sel_t pc_sel;
  } stack_req_t;

endpackage

// ==== verilog/opcode_decoder.sv ====
`timescale 1ns/100ps

`include "cpu_ctrl_consts.svh"

module opcode_decoder
  import cpu_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  opcode_t      opcode,
  output decode_ctrl_t dec,
  output logic         ldm_freeze,
  output logic         ldm_value
);

  ldm_state_e ldm_state;
  ldm_state_e ldm_next;

  logic is_ldm;
  logic is_pop;
  logic is_load;
  logic is_imm;
  logic is_reg_wr;

  assign is_ldm  = (opcode == `OP_LDM);
  assign is_pop  = (opcode == `OP_POP);
  assign is_load = (opcode == `OP_LOAD);
  assign is_imm  = (opcode == `OP_IMM_A) || (opcode == `OP_IMM_B);

  // alu results, pops and loads all write back
  assign is_reg_wr = (opcode == `OP_REG_A) || (opcode == `OP_REG_B) ||
                     (opcode == `OP_REG_C) || (opcode == `OP_REG_D) ||
                     (opcode[4:3] == `OP_REG_HI) ||
                     is_pop || is_ldm || is_load;

  always_comb
  begin
    dec = '0;
    if (!rst)
    begin
      dec.alu_op     = opcode;
      dec.alu_src    = {is_ldm, is_imm};
      dec.reg_write  = is_reg_wr;
      dec.mem_read   = is_pop || is_load;
      dec.mem_write  = (opcode == `OP_PUSH) || (opcode == `OP_STORE);
      dec.mem_to_reg = is_pop || is_load;
      dec.stack      = is_pop || (opcode == `OP_PUSH);
      dec.ldm        = is_ldm;
      dec.branch     = (opcode[4:2] == `OP_BRANCH_HI);
      dec.port_read  = (opcode == `OP_IN);
      dec.port_write = (opcode == `OP_OUT);
      dec.call       = (opcode == `OP_CALL);
      dec.ret        = (opcode == `OP_RET);
      dec.rti        = (opcode == `OP_RTI);
    end
  end

  // the immediate word follows ldm, so hold the cu for one cycle
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ldm_state <= LDM_IDLE;
    end
    else
    begin
      ldm_state <= ldm_next;
    end
  end

  always_comb
  begin
    ldm_next = LDM_IDLE;
    if (ldm_state == LDM_IDLE && dec.ldm)
    begin
      ldm_next = LDM_HOLD;
    end
  end

  assign ldm_freeze = (ldm_state == LDM_IDLE) && dec.ldm;
  assign ldm_value  = (ldm_state == LDM_HOLD);

endmodule

// ==== verilog/call_ret_seq.sv ====
`timescale 1ns/100ps

`include "cpu_ctrl_consts.svh"

module call_ret_seq
  import cpu_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       call,
  input  logic       ret,
  output stack_req_t call_req,
  output stack_req_t ret_req
);

  call_state_e call_state;
  call_state_e call_next;
  ret_state_e  ret_state;
  ret_state_e  ret_next;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      call_state <= CALL_IDLE;
      ret_state  <= RET_IDLE;
    end
    else
    begin
      call_state <= call_next;
      ret_state  <= ret_next;
    end
  end

  // call pushes the return pc low half at once, high half next cycle
  always_comb
  begin
    call_req  = '0;
    call_next = CALL_IDLE;
    case (call_state)
      CALL_IDLE:
      begin
        if (call)
        begin
          call_req.pc_sel       = `PC_SEL_JUMP;
          call_req.mem_write    = 1'b1;
          call_req.stack        = 1'b1;
          call_req.pc_to_stack1 = 1'b1;
          call_next             = CALL_PUSH_HI;
        end
      end
      CALL_PUSH_HI:
      begin
        call_req.mem_write    = 1'b1;
        call_req.stack        = 1'b1;
        call_req.pc_to_stack2 = 1'b1;
        // the instruction fetched behind the call is dropped
        call_req.flush        = 1'b1;
      end
      default:
      begin
        call_next = CALL_IDLE;
      end
    endcase
  end

  // return waits two cycles, then pops high half and low half
  always_comb
  begin
    ret_req  = '0;
    ret_next = RET_IDLE;
    case (ret_state)
      RET_IDLE:
      begin
        if (ret)
        begin
          ret_next = RET_WAIT;
        end
      end
      RET_WAIT:
      begin
        ret_next = RET_POP_HI;
      end
      RET_POP_HI, RET_POP_LO:
      begin
        ret_req.mem_read  = 1'b1;
        ret_req.stack     = 1'b1;
        ret_req.freeze_pc = 1'b1;
        ret_req.freeze_cu = 1'b1;
        ret_req.pop_pc2   = (ret_state == RET_POP_HI);
        ret_req.pop_pc1   = (ret_state == RET_POP_LO);
        ret_req.pc_sel    = `PC_SEL_NEXT;
        ret_next          = (ret_state == RET_POP_HI) ? RET_POP_LO : RET_IDLE;
      end
      default:
      begin
        ret_next = RET_IDLE;
      end
    endcase
  end

endmodule

// ==== verilog/int_rti_seq.sv ====
`timescale 1ns/100ps

`include "cpu_ctrl_consts.svh"

module int_rti_seq
  import cpu_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       interrupt,
  input  logic       rti,
  input  logic       ldm,
  input  logic       load_use,
  input  logic       branch_taken,
  output logic       ack,
  output stack_req_t int_req,
  output stack_req_t rti_req
);

  int_state_e int_state;
  int_state_e int_next;
  rti_state_e rti_state;
  rti_state_e rti_next;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      int_state <= INT_IDLE;
      rti_state <= RTI_IDLE;
    end
    else
    begin
      int_state <= int_next;
      rti_state <= rti_next;
    end
  end

  assign ack = (int_state == INT_ACK);

  always_comb
  begin
    int_next = INT_IDLE;
    case (int_state)
      INT_IDLE:        int_next = interrupt ? INT_ACK : INT_IDLE;
      // an ldm or load-use in flight needs one more cycle to drain
      INT_ACK:         int_next = (ldm || load_use) ? INT_HAZARD_WAIT : INT_FREEZE_PC;
      INT_HAZARD_WAIT: int_next = INT_FREEZE_PC;
      INT_FREEZE_PC:   int_next = INT_FREEZE_CU;
      INT_FREEZE_CU:   int_next = INT_WAIT_3;
      INT_WAIT_3:      int_next = INT_WAIT_4;
      INT_WAIT_4:      int_next = INT_PUSH_LO;
      INT_PUSH_LO:     int_next = INT_PUSH_HI;
      INT_PUSH_HI:     int_next = INT_PUSH_FLAGS;
      default:         int_next = INT_IDLE;
    endcase
  end

  always_comb
  begin
    int_req = '0;
    case (int_state)
      INT_IDLE:
      begin
        // a taken branch must still load its target
        int_req.freeze_pc = interrupt && !branch_taken;
      end
      INT_ACK:
      begin
        int_req.freeze_pc = !branch_taken;
      end
      INT_HAZARD_WAIT, INT_FREEZE_PC:
      begin
        int_req.freeze_pc = 1'b1;
      end
      INT_FREEZE_CU, INT_WAIT_3, INT_WAIT_4:
      begin
        int_req.freeze_pc = 1'b1;
        int_req.freeze_cu = 1'b1;
      end
      INT_PUSH_LO, INT_PUSH_HI:
      begin
        int_req.freeze_pc    = 1'b1;
        int_req.freeze_cu    = 1'b1;
        int_req.mem_write    = 1'b1;
        int_req.stack        = 1'b1;
        int_req.pc_to_stack1 = (int_state == INT_PUSH_LO);
        int_req.pc_to_stack2 = (int_state == INT_PUSH_HI);
      end
      INT_PUSH_FLAGS:
      begin
        // pc released here so the vector gets loaded
        int_req.freeze_cu    = 1'b1;
        int_req.mem_write    = 1'b1;
        int_req.stack        = 1'b1;
        int_req.ccr_to_stack = 1'b1;
        int_req.pc_sel       = `PC_SEL_INT;
      end
      default:
      begin
        int_req = '0;
      end
    endcase
  end

  // rti pops flags, pc high, pc low back to back
  always_comb
  begin
    rti_req  = '0;
    rti_next = RTI_IDLE;
    case (rti_state)
      RTI_IDLE:      rti_next = rti ? RTI_POP_FLAGS : RTI_IDLE;
      RTI_POP_FLAGS: rti_next = RTI_POP_HI;
      RTI_POP_HI:    rti_next = RTI_POP_LO;
      default:       rti_next = RTI_IDLE;
    endcase
    if (rti_state != RTI_IDLE)
    begin
      rti_req.mem_read  = 1'b1;
      rti_req.stack     = 1'b1;
      rti_req.freeze_pc = 1'b1;
      rti_req.freeze_cu = 1'b1;
      rti_req.pop_ccr   = (rti_state == RTI_POP_FLAGS);
      rti_req.pop_pc2   = (rti_state == RTI_POP_HI);
      rti_req.pop_pc1   = (rti_state == RTI_POP_LO);
    end
  end

endmodule

// ==== verilog/ctrl_merge.sv ====
`timescale 1ns/100ps

`include "cpu_ctrl_consts.svh"

module ctrl_merge
  import cpu_ctrl_pkg::*;
(
  input  logic          rst,
  input  decode_ctrl_t  dec,
  input  logic          ldm_freeze,
  input  stack_req_t    call_req,
  input  stack_req_t    ret_req,
  input  stack_req_t    int_req,
  input  stack_req_t    rti_req,
  input  logic          branch_taken,
  input  logic          load_use,
  output decode_ctrl_t  ctrl,
  output mem_data_sel_t mem_data_sel,
  output pc_sel_t       pc_sel,
  output logic          pop_pc1,
  output logic          pop_pc2,
  output logic          pop_ccr,
  output logic          fetch_pc_enable,
  output logic          freeze_cu,
  output logic          flush_fetch
);

  stack_req_t seq;
  logic       freeze_pc;

  // sequences never overlap, so a plain OR combines them
  assign seq = rst ? '0 : (call_req | ret_req | int_req | rti_req);

  always_comb
  begin
    ctrl           = dec;
    ctrl.mem_read  = dec.mem_read  | seq.mem_read;
    ctrl.mem_write = dec.mem_write | seq.mem_write;
    ctrl.stack     = dec.stack     | seq.stack;
  end

  always_comb
  begin
    if (seq.pc_to_stack1)
      mem_data_sel = `MEM_DATA_PC_LO;
    else if (seq.pc_to_stack2)
      mem_data_sel = `MEM_DATA_PC_HI;
    else if (seq.ccr_to_stack)
      mem_data_sel = `MEM_DATA_FLAGS;
    else
      mem_data_sel = `MEM_DATA_REG;
  end

  assign pc_sel = rst ? `PC_SEL_NEXT :
                  (branch_taken ? `PC_SEL_JUMP : seq.pc_sel);

  assign pop_pc1 = seq.pop_pc1;
  assign pop_pc2 = seq.pop_pc2;
  assign pop_ccr = seq.pop_ccr;

  assign freeze_pc       = seq.freeze_pc;
  assign fetch_pc_enable = !freeze_pc;

  assign freeze_cu   = !rst && (load_use || ldm_freeze || seq.freeze_cu);
  assign flush_fetch = !rst && (branch_taken || seq.flush);

endmodule

// ==== verilog/cpu_ctrl_top.sv ====
`timescale 1ns/100ps

module cpu_ctrl_top
  import cpu_ctrl_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  opcode_t       opcode,
  input  logic          interrupt,
  input  logic          branch_taken,
  input  logic          load_use,
  output decode_ctrl_t  ctrl,
  output logic          ldm_value,
  output logic          ack,
  output mem_data_sel_t mem_data_sel,
  output pc_sel_t       pc_sel,
  output logic          pop_pc1,
  output logic          pop_pc2,
  output logic          pop_ccr,
  output logic          fetch_pc_enable,
  output logic          freeze_cu,
  output logic          flush_fetch
);

  decode_ctrl_t dec;
  logic         ldm_freeze;
  stack_req_t   call_req;
  stack_req_t   ret_req;
  stack_req_t   int_req;
  stack_req_t   rti_req;

  opcode_decoder u_decoder (
    .clk        (clk),
    .rst        (rst),
    .opcode     (opcode),
    .dec        (dec),
    .ldm_freeze (ldm_freeze),
    .ldm_value  (ldm_value)
  );

  call_ret_seq u_call_ret (
    .clk      (clk),
    .rst      (rst),
    .call     (dec.call),
    .ret      (dec.ret),
    .call_req (call_req),
    .ret_req  (ret_req)
  );

  int_rti_seq u_int_rti (
    .clk          (clk),
    .rst          (rst),
    .interrupt    (interrupt),
    .rti          (dec.rti),
    .ldm          (dec.ldm),
    .load_use     (load_use),
    .branch_taken (branch_taken),
    .ack          (ack),
    .int_req      (int_req),
    .rti_req      (rti_req)
  );

  ctrl_merge u_merge (
    .rst             (rst),
    .dec             (dec),
    .ldm_freeze      (ldm_freeze),
    .call_req        (call_req),
    .ret_req         (ret_req),
    .int_req         (int_req),
    .rti_req         (rti_req),
    .branch_taken    (branch_taken),
    .load_use        (load_use),
    .ctrl            (ctrl),
    .mem_data_sel    (mem_data_sel),
    .pc_sel          (pc_sel),
    .pop_pc1         (pop_pc1),
    .pop_pc2         (pop_pc2),
    .pop_ccr         (pop_ccr),
    .fetch_pc_enable (fetch_pc_enable),
    .freeze_cu       (freeze_cu),
    .flush_fetch     (flush_fetch)
  );

endmodule

// ==== tb/cpu_ctrl_checker.sv ====
`timescale 1ns/100ps

module cpu_ctrl_checker
  import cpu_ctrl_pkg::*;
(
  input logic          clk,
  input logic          rst,
  input logic          ack,
  input decode_ctrl_t  ctrl,
  input mem_data_sel_t mem_data_sel,
  input logic          fetch_pc_enable,
  input logic          freeze_pc,
  input logic          pc_to_stack1
);

  // ack is a single-cycle pulse
  ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else $error("ack held high for more than one cycle");

  mem_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(ctrl.mem_read && ctrl.mem_write))
    else $error("mem_read and mem_write high together");

  fetch_vs_freeze: assert property (@(posedge clk) disable iff (rst)
    fetch_pc_enable == !freeze_pc)
    else $error("fetch_pc_enable does not track the merged freeze_pc");

  pc_lo_select: assert property (@(posedge clk) disable iff (rst)
    pc_to_stack1 |-> mem_data_sel == 2'b01)
    else $error("pc low push without mem_data_sel 01");

endmodule

// ==== tb/cpu_ctrl_tb.sv ====
`timescale 1ns/100ps

`include "cpu_ctrl_consts.svh"

module cpu_ctrl_tb
  import cpu_ctrl_pkg::*;
();

  // decoder pass is about 150 cycles and the sequences about 45, so 600 leaves a wide margin
  localparam int TIMEOUT_CYCLES = 600;

  logic          clk;
  logic          rst;
  opcode_t       opcode;
  logic          interrupt;
  logic          branch_taken;
  logic          load_use;
  decode_ctrl_t  ctrl;
  logic          ldm_value;
  logic          ack;
  mem_data_sel_t mem_data_sel;
  pc_sel_t       pc_sel;
  logic          pop_pc1;
  logic          pop_pc2;
  logic          pop_ccr;
  logic          fetch_pc_enable;
  logic          freeze_cu;
  logic          flush_fetch;

  int          value_errors;
  int          other_errors;
  int          cycle_count = 0;
  logic [31:0] lfsr;

  opcode_t listed_ops [20] = '{`OP_PUSH, `OP_OUT, `OP_IN, `OP_POP, `OP_LDM, `OP_LOAD,
                               `OP_STORE, 5'b10100, 5'b10111, `OP_CALL, `OP_RET, `OP_RTI,
                               `OP_IMM_A, `OP_IMM_B, 5'b00011, 5'b00100, 5'b00101,
                               5'b01000, 5'b01010, 5'b00000};

  cpu_ctrl_top UUT (
    .clk             (clk),
    .rst             (rst),
    .opcode          (opcode),
    .interrupt       (interrupt),
    .branch_taken    (branch_taken),
    .load_use        (load_use),
    .ctrl            (ctrl),
    .ldm_value       (ldm_value),
    .ack             (ack),
    .mem_data_sel    (mem_data_sel),
    .pc_sel          (pc_sel),
    .pop_pc1         (pop_pc1),
    .pop_pc2         (pop_pc2),
    .pop_ccr         (pop_ccr),
    .fetch_pc_enable (fetch_pc_enable),
    .freeze_cu       (freeze_cu),
    .flush_fetch     (flush_fetch)
  );

  // freeze and push requests are taken straight from the four sequencers
  bind cpu_ctrl_top cpu_ctrl_checker u_checker (
    .clk             (clk),
    .rst             (rst),
    .ack             (ack),
    .ctrl            (ctrl),
    .mem_data_sel    (mem_data_sel),
    .fetch_pc_enable (fetch_pc_enable),
    .freeze_pc       (call_req.freeze_pc | ret_req.freeze_pc |
                      int_req.freeze_pc | rti_req.freeze_pc),
    .pc_to_stack1    (call_req.pc_to_stack1 | ret_req.pc_to_stack1 |
                      int_req.pc_to_stack1 | rti_req.pc_to_stack1)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
    cycle_count <= cycle_count + 1;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_random_opcode(output opcode_t op);
    for (int b = 0; b < 5; b++)
    begin
      lfsr  = lfsr_next(lfsr);
      op[b] = lfsr[0];
    end
  endtask

  // static fields straight from the opcode table
  function automatic decode_ctrl_t expected_ctrl(input opcode_t op);
    decode_ctrl_t e;
    logic         is_pop_load;
    e           = '0;
    is_pop_load = (op == `OP_POP) || (op == `OP_LOAD);
    e.alu_op    = op;
    e.alu_src   = {op == `OP_LDM, (op == `OP_IMM_A) || (op == `OP_IMM_B)};
    // pops, loads and ldm also write back
    e.reg_write  = (op == 5'b00011) || (op == 5'b00100) || (op == 5'b00101) ||
                   (op == 5'b01000) || (op[4:3] == 2'b01) || is_pop_load ||
                   (op == `OP_LDM);
    e.mem_read   = is_pop_load;
    e.mem_write  = (op == `OP_PUSH) || (op == `OP_STORE);
    e.mem_to_reg = is_pop_load;
    e.stack      = (op == `OP_POP) || (op == `OP_PUSH);
    e.ldm        = (op == `OP_LDM);
    e.branch     = (op[4:2] == 3'b101);
    e.port_read  = (op == `OP_IN);
    e.port_write = (op == `OP_OUT);
    e.call       = (op == `OP_CALL);
    e.ret        = (op == `OP_RET);
    e.rti        = (op == `OP_RTI);
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      value_errors++;
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond)
    else
    begin
      other_errors++;
      $display("error: %s", what);
    end
  endtask

  // drive on the falling edge, then let the combinational outputs settle
  task automatic drive_cycle(input opcode_t op, input logic intr, input logic bt,
                             input logic lu);
    @(negedge clk);
    opcode       = op;
    interrupt    = intr;
    branch_taken = bt;
    load_use     = lu;
    #5;
  endtask

  task automatic test_decoder();
    opcode_t      op;
    decode_ctrl_t exp_ctrl;
    @(negedge clk);
    rst          = 1'b1;
    opcode       = `OP_CALL;
    interrupt    = 1'b1;
    branch_taken = 1'b1;
    load_use     = 1'b1;
    #5;
    check_value("reset ctrl", 0, ctrl);
    check_value("reset outputs", 0, {ack, ldm_value, mem_data_sel, pc_sel, pop_ccr,
                                     pop_pc2, pop_pc1, freeze_cu, flush_fetch});
    check_value("reset fetch_pc_enable", 1, fetch_pc_enable);
    drive_cycle(5'b00000, 1'b0, 1'b0, 1'b0);
    rst = 1'b0;
    for (int i = 0; i < 84; i++)
    begin
      if (i < 64)
        take_random_opcode(op);
      else
        op = listed_ops[i - 64];
      drive_cycle(op, 1'b0, 1'b0, 1'b0);
      exp_ctrl = expected_ctrl(op);
      // the first call push lands in the strobe cycle
      if (op == `OP_CALL)
      begin
        exp_ctrl.mem_write = 1'b1;
        exp_ctrl.stack     = 1'b1;
      end
      check_value($sformatf("decoder op %b ctrl", op), exp_ctrl, ctrl);
      if (op == `OP_CALL || op == `OP_RET || op == `OP_RTI || op == `OP_LDM)
        repeat (4) drive_cycle(5'b00000, 1'b0, 1'b0, 1'b0);
    end
  endtask

  task automatic test_ldm_hazards();
    drive_cycle(`OP_LDM, 1'b0, 1'b0, 1'b0);
    check_value("ldm cycle 0 freeze_cu", 1, freeze_cu);
    check_value("ldm cycle 0 ldm_value", 0, ldm_value);
    drive_cycle(5'b00000, 1'b0, 1'b0, 1'b0);
    check_value("ldm cycle 1 ldm_value", 1, ldm_value);
    check_value("ldm cycle 1 freeze_cu", 0, freeze_cu);
    drive_cycle(5'b00000, 1'b0, 1'b0, 1'b1);
    check_value("load_use freeze_cu", 1, freeze_cu);
    check_value("load_use pc_sel", 0, pc_sel);
    drive_cycle(5'b00000, 1'b0, 1'b1, 1'b0);
    check_value("branch pc_sel", 2'b11, pc_sel);
    check_value("branch flush_fetch", 1, flush_fetch);
    check_value("branch freeze_cu", 0, freeze_cu);
    drive_cycle(5'b00000, 1'b0, 1'b0, 1'b0);
    check_value("after branch flush_fetch", 0, flush_fetch);
  endtask

  task automatic test_call();
    for (int c = 0; c < 3; c++)
    begin
      drive_cycle((c == 0) ? `OP_CALL : 5'b00000, 1'b0, 1'b0, 1'b0);
      check_value($sformatf("call cycle %0d mem_data_sel", c),
                  (c == 0) ? 2'b01 : ((c == 1) ? 2'b10 : 2'b00), mem_data_sel);
      check_value($sformatf("call cycle %0d pc_sel", c), (c == 0) ? 2'b11 : 2'b00, pc_sel);
      check_value($sformatf("call cycle %0d flush_fetch", c), c == 1, flush_fetch);
      check_value($sformatf("call cycle %0d mem_write", c), c < 2, ctrl.mem_write);
    end
  endtask

  task automatic test_ret_rti();
    logic popping;
    for (int c = 0; c < 4; c++)
    begin
      drive_cycle((c == 0) ? `OP_RET : 5'b00000, 1'b0, 1'b0, 1'b0);
      popping = (c == 2) || (c == 3);
      check_value($sformatf("ret cycle %0d pops", c), {1'b0, c == 2, c == 3},
                  {pop_ccr, pop_pc2, pop_pc1});
      check_value($sformatf("ret cycle %0d fetch_pc_enable", c), !popping, fetch_pc_enable);
      check_value($sformatf("ret cycle %0d mem_read", c), popping, ctrl.mem_read);
    end
    drive_cycle(5'b00000, 1'b0, 1'b0, 1'b0);
    check_true(fetch_pc_enable, "return left the fetch pc frozen");
    for (int c = 0; c < 4; c++)
    begin
      drive_cycle((c == 0) ? `OP_RTI : 5'b00000, 1'b0, 1'b0, 1'b0);
      check_value($sformatf("rti cycle %0d pops", c), {c == 1, c == 2, c == 3},
                  {pop_ccr, pop_pc2, pop_pc1});
      check_value($sformatf("rti cycle %0d fetch_pc_enable", c), c == 0, fetch_pc_enable);
      check_value($sformatf("rti cycle %0d freeze_cu", c), c != 0, freeze_cu);
    end
    drive_cycle(5'b00000, 1'b0, 1'b0, 1'b0);
    check_true(fetch_pc_enable, "return from interrupt left the fetch pc frozen");
  endtask

  // a load_use at ack delays everything from freeze_cu on by one cycle
  task automatic test_interrupt(input logic hazard);
    int    d;
    string tag;
    d   = hazard ? 1 : 0;
    tag = hazard ? "interrupt load_use" : "interrupt";
    for (int c = 0; c <= 8 + d; c++)
    begin
      drive_cycle(5'b00000, c == 0, 1'b0, hazard && (c == 1));
      check_value($sformatf("%s cycle %0d ack", tag, c), c == 1, ack);
      check_value($sformatf("%s cycle %0d mem_data_sel", tag, c),
                  (c == 6 + d) ? 2'b01 : ((c == 7 + d) ? 2'b10 : ((c == 8 + d) ? 2'b11 : 2'b00)),
                  mem_data_sel);
      check_value($sformatf("%s cycle %0d pc_sel", tag, c), (c == 8 + d) ? 2'b10 : 2'b00,
                  pc_sel);
      check_value($sformatf("%s cycle %0d fetch_pc_enable", tag, c), c == 8 + d,
                  fetch_pc_enable);
      check_value($sformatf("%s cycle %0d freeze_cu", tag, c),
                  (c >= 3 + d) || (hazard && (c == 1)), freeze_cu);
    end
    drive_cycle(5'b00000, 1'b0, 1'b0, 1'b0);
    check_true(fetch_pc_enable && !freeze_cu, "interrupt entry did not release the pipeline");
  endtask

  initial
  begin
    rst          = 1'b1;
    opcode       = 5'b00000;
    interrupt    = 1'b0;
    branch_taken = 1'b0;
    load_use     = 1'b0;
    value_errors = 0;
    other_errors = 0;
    lfsr         = 32'h74f8;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    test_decoder();
    test_ldm_hazards();
    test_call();
    test_ret_rti();
    test_interrupt(1'b0);
    test_interrupt(1'b1);
    drive_cycle(5'b00000, 1'b0, 1'b0, 1'b0);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== cpu_ctrl.f ====
+incdir+verilog
verilog/cpu_ctrl_pkg.sv
verilog/opcode_decoder.sv
verilog/call_ret_seq.sv
verilog/int_rti_seq.sv
verilog/ctrl_merge.sv
verilog/cpu_ctrl_top.sv
tb/cpu_ctrl_checker.sv
tb/cpu_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cpu_ctrl_pkg.sv
      - verilog/opcode_decoder.sv
      - verilog/call_ret_seq.sv
      - verilog/int_rti_seq.sv
      - verilog/ctrl_merge.sv
      - verilog/cpu_ctrl_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - tb/cpu_ctrl_checker.sv
      - tb/cpu_ctrl_tb.sv
